// File: build.f
rv32i_pkg.sv
pipe_pkg.sv
pipe_reg.sv
decoder.sv
regfile.sv
hazard_unit.sv
ex_stage.sv
datapath.sv
datapath_properties.sv
tb_datapath.sv

// File: datapath.sv
// five-stage RV32I core top: PC, stage registers, hazard control and memory ports
// both memories answer combinationally, no handshake beyond the strobes
`timescale 1ns/100ps

module datapath (
    input  logic             clk,
    input  logic             arst_n_i,
    input  rv32i_pkg::word_t instr_mem_rdata_i,
    input  rv32i_pkg::word_t data_mem_rdata_i,
    output rv32i_pkg::word_t instr_mem_address_o,
    output rv32i_pkg::word_t data_mem_address_o,
    output rv32i_pkg::word_t data_mem_wdata_o,
    output logic             instr_mem_read_o,
    output logic             data_mem_read_o,
    output logic             data_mem_write_o
);

    rv32i_pkg::word_t    pc;
    // first fetch one cycle after reset release
    logic                fetch_en;
    // pc advance and IF/ID load
    logic                fetch_go;
    logic                stall;
    pipe_pkg::if_id_t    if_id_d, if_id_q;
    pipe_pkg::id_ex_t    id_ex_d, id_ex_q;
    pipe_pkg::ex_mem_t   ex_mem_d, ex_mem_q;
    pipe_pkg::mem_wb_t   mem_wb_d, mem_wb_q;
    pipe_pkg::ctrl_t     dec_ctrl;
    rv32i_pkg::reg_idx_t dec_rs1, dec_rs2, dec_rd;
    rv32i_pkg::word_t    dec_imm, rf_rdata1, rf_rdata2;
    pipe_pkg::fwd_sel_e  fwd_a, fwd_b;
    // writeback value, to regfile and forwarding
    rv32i_pkg::word_t    wb_val;

    assign fetch_go = fetch_en && !stall;

    // pc holds on load-use stall
    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            pc       <= rv32i_pkg::reset_pc;
            fetch_en <= 1'b0;
        end else begin
            fetch_en <= 1'b1;
            if (fetch_go) begin
                pc <= pc + rv32i_pkg::pc_step;
            end
        end
    end

    // fetch
    assign instr_mem_address_o = pc;
    assign instr_mem_read_o    = fetch_go;
    assign if_id_d             = '{pc: pc, instr: instr_mem_rdata_i};

    pipe_reg #(.payload_t(pipe_pkg::if_id_t)) if_id_reg (
        .clk(clk), .arst_n_i(arst_n_i), .load_i(fetch_go), .bubble_i(1'b0),
        .d_i(if_id_d), .q_o(if_id_q)
    );

    // decode
    decoder decoder_inst (
        .instr_i(if_id_q.instr), .ctrl_o(dec_ctrl), .rs1_o(dec_rs1), .rs2_o(dec_rs2),
        .rd_o(dec_rd), .imm_o(dec_imm)
    );

    regfile regfile_inst (
        .clk(clk), .arst_n_i(arst_n_i), .we_i(mem_wb_q.reg_write), .waddr_i(mem_wb_q.rd),
        .raddr1_i(dec_rs1), .raddr2_i(dec_rs2), .wdata_i(wb_val),
        .rdata1_o(rf_rdata1), .rdata2_o(rf_rdata2)
    );

    assign id_ex_d = '{ctrl: dec_ctrl, rs1: dec_rs1, rs2: dec_rs2, rd: dec_rd,
                       rs1_val: rf_rdata1, rs2_val: rf_rdata2, imm: dec_imm};

    hazard_unit hazard_unit_inst (
        .id_rs1_i(dec_rs1), .id_rs2_i(dec_rs2), .id_ex_i(id_ex_q), .ex_mem_i(ex_mem_q),
        .mem_wb_i(mem_wb_q), .fwd_a_o(fwd_a), .fwd_b_o(fwd_b), .stall_o(stall)
    );

    // bubble into execute while the load-use pair resolves
    pipe_reg #(.payload_t(pipe_pkg::id_ex_t)) id_ex_reg (
        .clk(clk), .arst_n_i(arst_n_i), .load_i(1'b1), .bubble_i(stall),
        .d_i(id_ex_d), .q_o(id_ex_q)
    );

    // execute
    ex_stage ex_stage_inst (
        .id_ex_i(id_ex_q), .fwd_a_i(fwd_a), .fwd_b_i(fwd_b), .mem_fwd_i(ex_mem_q.alu_res),
        .wb_fwd_i(wb_val), .ex_mem_o(ex_mem_d)
    );

    pipe_reg #(.payload_t(pipe_pkg::ex_mem_t)) ex_mem_reg (
        .clk(clk), .arst_n_i(arst_n_i), .load_i(1'b1), .bubble_i(1'b0),
        .d_i(ex_mem_d), .q_o(ex_mem_q)
    );

    // memory, strobes straight from EX/MEM
    assign data_mem_address_o = ex_mem_q.alu_res;
    assign data_mem_wdata_o   = ex_mem_q.store_val;
    assign data_mem_read_o    = ex_mem_q.ctrl.mem_read;
    assign data_mem_write_o   = ex_mem_q.ctrl.mem_write;
    assign mem_wb_d = '{reg_write: ex_mem_q.ctrl.reg_write, mem_read: ex_mem_q.ctrl.mem_read,
                        rd: ex_mem_q.rd, alu_res: ex_mem_q.alu_res, load_val: data_mem_rdata_i};

    pipe_reg #(.payload_t(pipe_pkg::mem_wb_t)) mem_wb_reg (
        .clk(clk), .arst_n_i(arst_n_i), .load_i(1'b1), .bubble_i(1'b0),
        .d_i(mem_wb_d), .q_o(mem_wb_q)
    );

    // writeback select
    assign wb_val = mem_wb_q.mem_read ? mem_wb_q.load_val : mem_wb_q.alu_res;

endmodule

// File: datapath_properties.sv
// concurrent checks on the memory strobes and the load-use stall
// bound into the core top from the testbench side
`timescale 1ns/100ps

module datapath_properties (
    input logic             clk,
    input logic             arst_n_i,
    input logic             stall_i,
    input rv32i_pkg::word_t pc_i,
    input logic             instr_mem_read_i,
    input logic             data_mem_read_i,
    input logic             data_mem_write_i
);

    // one data access per instruction in MEM
    strobe_exclusive: assert property (@(posedge clk) disable iff (!arst_n_i)
        !(data_mem_read_i && data_mem_write_i))
        else $error("data memory read and write strobes high together");

    // quiet buses while reset is held
    strobe_in_reset: assert property (@(posedge clk)
        !arst_n_i |-> !(instr_mem_read_i || data_mem_read_i || data_mem_write_i))
        else $error("memory strobe high during reset");

    // bubble cycle keeps fetch in place
    stall_holds_pc: assert property (@(posedge clk) disable iff (!arst_n_i)
        stall_i |=> $stable(pc_i))
        else $error("pc moved in the cycle after a load-use stall");

endmodule

bind datapath datapath_properties datapath_properties_inst (
    .clk(clk), .arst_n_i(arst_n_i), .stall_i(stall), .pc_i(pc),
    .instr_mem_read_i(instr_mem_read_o), .data_mem_read_i(data_mem_read_o),
    .data_mem_write_i(data_mem_write_o)
);

// File: decoder.sv
// decode stage: instruction word to control word, immediate and register indices
// unused indices come out as x0 so they never raise a hazard
`timescale 1ns/100ps

module decoder (
    input  rv32i_pkg::word_t    instr_i,
    output pipe_pkg::ctrl_t     ctrl_o,
    output rv32i_pkg::reg_idx_t rs1_o,
    output rv32i_pkg::reg_idx_t rs2_o,
    output rv32i_pkg::reg_idx_t rd_o,
    output rv32i_pkg::word_t    imm_o
);

    logic [6:0]       opcode;
    logic [2:0]       funct3;
    // funct7 bit 5, sub and sra
    logic             alt;
    rv32i_pkg::word_t i_imm;
    rv32i_pkg::word_t s_imm;
    rv32i_pkg::word_t u_imm;

    // funct3 to alu op, the alt bit only turns add into sub for OP
    function automatic rv32i_pkg::alu_op_e alu_sel(
        input logic [2:0] f3,
        input logic       alt_bit,
        input logic       is_reg
    );
        case (f3)
            rv32i_pkg::f3_add:  return (alt_bit && is_reg) ? rv32i_pkg::alu_sub : rv32i_pkg::alu_add;
            rv32i_pkg::f3_sll:  return rv32i_pkg::alu_sll;
            rv32i_pkg::f3_slt:  return rv32i_pkg::alu_slt;
            rv32i_pkg::f3_sltu: return rv32i_pkg::alu_sltu;
            rv32i_pkg::f3_xor:  return rv32i_pkg::alu_xor;
            rv32i_pkg::f3_sr:   return alt_bit ? rv32i_pkg::alu_sra : rv32i_pkg::alu_srl;
            rv32i_pkg::f3_or:   return rv32i_pkg::alu_or;
            default:            return rv32i_pkg::alu_and;
        endcase
    endfunction

    // fixed fields
    assign opcode = instr_i[6:0];
    assign funct3 = instr_i[14:12];
    assign alt    = instr_i[30];

    // sign-extended I and S, U already in place
    assign i_imm = {{20{instr_i[31]}}, instr_i[31:20]};
    assign s_imm = {{20{instr_i[31]}}, instr_i[31:25], instr_i[11:7]};
    assign u_imm = {instr_i[31:12], 12'b0};

    always_comb begin
        // nop unless a known opcode matches
        ctrl_o = '0;
        imm_o  = '0;
        rs1_o  = '0;
        rs2_o  = '0;
        rd_o   = '0;
        case (opcode)
            rv32i_pkg::op_reg: begin
                ctrl_o.alu_op    = alu_sel(funct3, alt, 1'b1);
                ctrl_o.reg_write = 1'b1;
                rs1_o            = instr_i[19:15];
                rs2_o            = instr_i[24:20];
                rd_o             = instr_i[11:7];
            end
            rv32i_pkg::op_imm: begin
                ctrl_o.alu_op    = alu_sel(funct3, alt, 1'b0);
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.reg_write = 1'b1;
                imm_o            = i_imm;
                rs1_o            = instr_i[19:15];
                rd_o             = instr_i[11:7];
            end
            rv32i_pkg::op_lui: begin
                // U immediate straight to rd
                ctrl_o.alu_op    = rv32i_pkg::alu_pass_b;
                ctrl_o.use_imm   = 1'b1;
                ctrl_o.reg_write = 1'b1;
                imm_o            = u_imm;
                rd_o             = instr_i[11:7];
            end
            rv32i_pkg::op_load: begin
                if (funct3 == rv32i_pkg::f3_lw_sw) begin
                    // address is rs1 plus offset, add is the zero op
                    ctrl_o.use_imm   = 1'b1;
                    ctrl_o.mem_read  = 1'b1;
                    ctrl_o.reg_write = 1'b1;
                    imm_o            = i_imm;
                    rs1_o            = instr_i[19:15];
                    rd_o             = instr_i[11:7];
                end
            end
            rv32i_pkg::op_store: begin
                if (funct3 == rv32i_pkg::f3_lw_sw) begin
                    ctrl_o.use_imm   = 1'b1;
                    ctrl_o.mem_write = 1'b1;
                    imm_o            = s_imm;
                    rs1_o            = instr_i[19:15];
                    // store data source
                    rs2_o            = instr_i[24:20];
                end
            end
            default: ;
        endcase
    end

endmodule

// File: ex_stage.sv
// execute stage: operand forwarding, operand b select and the integer alu
// combinational, output goes straight into the EX/MEM register
`timescale 1ns/100ps

module ex_stage (
    input  pipe_pkg::id_ex_t   id_ex_i,
    input  pipe_pkg::fwd_sel_e fwd_a_i,
    input  pipe_pkg::fwd_sel_e fwd_b_i,
    // alu result held in EX/MEM
    input  rv32i_pkg::word_t   mem_fwd_i,
    // final writeback value
    input  rv32i_pkg::word_t   wb_fwd_i,
    output pipe_pkg::ex_mem_t  ex_mem_o
);

    rv32i_pkg::word_t op_a;
    rv32i_pkg::word_t rs2_fwd;
    rv32i_pkg::word_t op_b;
    rv32i_pkg::word_t alu_res;
    logic [4:0]       shamt;

    // one forwarding mux, used for both sources
    function automatic rv32i_pkg::word_t fwd_mux(
        input pipe_pkg::fwd_sel_e sel,
        input rv32i_pkg::word_t   reg_val,
        input rv32i_pkg::word_t   mem_val,
        input rv32i_pkg::word_t   wb_val
    );
        case (sel)
            pipe_pkg::fwd_from_mem: return mem_val;
            pipe_pkg::fwd_from_wb:  return wb_val;
            default:                return reg_val;
        endcase
    endfunction

    assign op_a    = fwd_mux(fwd_a_i, id_ex_i.rs1_val, mem_fwd_i, wb_fwd_i);
    assign rs2_fwd = fwd_mux(fwd_b_i, id_ex_i.rs2_val, mem_fwd_i, wb_fwd_i);
    // immediate for OP-IMM, LUI and address math
    assign op_b    = id_ex_i.ctrl.use_imm ? id_ex_i.imm : rs2_fwd;
    assign shamt   = op_b[4:0];

    always_comb begin
        case (id_ex_i.ctrl.alu_op)
            rv32i_pkg::alu_add:    alu_res = op_a + op_b;
            rv32i_pkg::alu_sub:    alu_res = op_a - op_b;
            rv32i_pkg::alu_sll:    alu_res = op_a << shamt;
            rv32i_pkg::alu_slt:    alu_res = {31'b0, $signed(op_a) < $signed(op_b)};
            rv32i_pkg::alu_sltu:   alu_res = {31'b0, op_a < op_b};
            rv32i_pkg::alu_xor:    alu_res = op_a ^ op_b;
            rv32i_pkg::alu_srl:    alu_res = op_a >> shamt;
            // sign fill from bit 31
            rv32i_pkg::alu_sra:    alu_res = $signed(op_a) >>> shamt;
            rv32i_pkg::alu_or:     alu_res = op_a | op_b;
            rv32i_pkg::alu_and:    alu_res = op_a & op_b;
            rv32i_pkg::alu_pass_b: alu_res = op_b;
            default:               alu_res = '0;
        endcase
    end

    // store data is the forwarded rs2, not operand b
    always_comb begin
        ex_mem_o.ctrl      = id_ex_i.ctrl;
        ex_mem_o.rd        = id_ex_i.rd;
        ex_mem_o.alu_res   = alu_res;
        ex_mem_o.store_val = rs2_fwd;
    end

endmodule

// File: hazard_unit.sv
// forwarding selects for execute and the load-use stall for fetch and decode
// purely combinational, reads the stage payloads directly
`timescale 1ns/100ps

module hazard_unit (
    // sources of the instruction in decode
    input  rv32i_pkg::reg_idx_t id_rs1_i,
    input  rv32i_pkg::reg_idx_t id_rs2_i,
    input  pipe_pkg::id_ex_t    id_ex_i,
    input  pipe_pkg::ex_mem_t   ex_mem_i,
    input  pipe_pkg::mem_wb_t   mem_wb_i,
    output pipe_pkg::fwd_sel_e  fwd_a_o,
    output pipe_pkg::fwd_sel_e  fwd_b_o,
    output logic                stall_o
);

    // youngest producer first
    function automatic pipe_pkg::fwd_sel_e fwd_pick(
        input rv32i_pkg::reg_idx_t src,
        input pipe_pkg::ex_mem_t   em,
        input pipe_pkg::mem_wb_t   mw
    );
        if (em.ctrl.reg_write && em.rd != '0 && em.rd == src) begin
            return pipe_pkg::fwd_from_mem;
        end
        if (mw.reg_write && mw.rd != '0 && mw.rd == src) begin
            return pipe_pkg::fwd_from_wb;
        end
        return pipe_pkg::fwd_none;
    endfunction

    // execute stage operands
    assign fwd_a_o = fwd_pick(id_ex_i.rs1, ex_mem_i, mem_wb_i);
    assign fwd_b_o = fwd_pick(id_ex_i.rs2, ex_mem_i, mem_wb_i);

    // load in execute feeding decode
    // data only exists after memory, so one bubble goes in
    // afterwards the value comes from writeback
    always_comb begin
        stall_o = 1'b0;
        if (id_ex_i.ctrl.mem_read && id_ex_i.rd != '0) begin
            // decoder zeroes unused sources, no false stall
            if (id_ex_i.rd == id_rs1_i || id_ex_i.rd == id_rs2_i) begin
                stall_o = 1'b1;
            end
        end
    end

endmodule

// File: pipe_pkg.sv
// stage payloads, control word and forwarding selects of the five-stage pipe
// all-zero payload of any stage is a bubble
package pipe_pkg;

    // control word built in decode
    // travels with the instruction up to memory
    typedef struct packed {
        rv32i_pkg::alu_op_e alu_op;
        // operand b from the immediate instead of rs2
        logic               use_imm;
        logic               mem_read;
        logic               mem_write;
        logic               reg_write;
    } ctrl_t;

    // fetch to decode
    typedef struct packed {
        rv32i_pkg::word_t pc;
        rv32i_pkg::word_t instr;
    } if_id_t;

    // decode to execute
    // source indices stay along for forwarding
    typedef struct packed {
        ctrl_t               ctrl;
        rv32i_pkg::reg_idx_t rs1;
        rv32i_pkg::reg_idx_t rs2;
        rv32i_pkg::reg_idx_t rd;
        rv32i_pkg::word_t    rs1_val;
        rv32i_pkg::word_t    rs2_val;
        rv32i_pkg::word_t    imm;
    } id_ex_t;

    // execute to memory
    typedef struct packed {
        ctrl_t               ctrl;
        rv32i_pkg::reg_idx_t rd;
        // result or effective address
        rv32i_pkg::word_t    alu_res;
        rv32i_pkg::word_t    store_val;
    } ex_mem_t;

    // memory to writeback
    typedef struct packed {
        logic                reg_write;
        // picks load_val over alu_res
        logic                mem_read;
        rv32i_pkg::reg_idx_t rd;
        rv32i_pkg::word_t    alu_res;
        rv32i_pkg::word_t    load_val;
    } mem_wb_t;

    // execute operand source
    typedef enum logic [1:0] {
        fwd_none     = 2'd0,
        fwd_from_mem = 2'd1,
        fwd_from_wb  = 2'd2
    } fwd_sel_e;

endpackage

// File: pipe_reg.sv
// one stage register of the pipe, shared by all four stage boundaries
// bubble wins over load, reset and bubble both leave an all-zero payload
`timescale 1ns/100ps

module pipe_reg #(
    parameter type payload_t = logic
) (
    input  logic     clk,
    input  logic     arst_n_i,
    // capture d_i this cycle
    input  logic     load_i,
    // capture a bubble instead
    input  logic     bubble_i,
    input  payload_t d_i,
    output payload_t q_o
);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            // empty stage after reset
            q_o <= '0;
        end else if (bubble_i) begin
            // zero control means no write and no memory strobe
            q_o <= '0;
        end else if (load_i) begin
            q_o <= d_i;
        end
        // otherwise hold
    end

endmodule

// File: regfile.sv
// integer register file, two read ports and one write port
// the writeback write shows up on the read ports in the same cycle
`timescale 1ns/100ps

module regfile (
    input  logic                clk,
    input  logic                arst_n_i,
    input  logic                we_i,
    input  rv32i_pkg::reg_idx_t waddr_i,
    input  rv32i_pkg::reg_idx_t raddr1_i,
    input  rv32i_pkg::reg_idx_t raddr2_i,
    input  rv32i_pkg::word_t    wdata_i,
    output rv32i_pkg::word_t    rdata1_o,
    output rv32i_pkg::word_t    rdata2_o
);

    rv32i_pkg::word_t regs [rv32i_pkg::nreg];
    // effective write, x0 never written
    logic             wr;

    assign wr = we_i && (waddr_i != '0);

    always_ff @(posedge clk or negedge arst_n_i) begin
        if (!arst_n_i) begin
            for (int i = 0; i < rv32i_pkg::nreg; i++) begin
                regs[i] <= '0;
            end
        end else if (wr) begin
            regs[waddr_i] <= wdata_i;
        end
    end

    // write-first bypass, x0 stays zero since wr is low for it
    assign rdata1_o = (wr && waddr_i == raddr1_i) ? wdata_i : regs[raddr1_i];
    assign rdata2_o = (wr && waddr_i == raddr2_i) ? wdata_i : regs[raddr2_i];

endmodule

// File: run.sh
#!/bin/sh
# compile with Verilator, run, then look for the pass line in the log
cd "$(dirname "$0")" || exit 1
rm -f sim.log build.log
verilator --binary --timing --assert -j 0 --top-module tb_datapath -f build.f \
    -o tb_datapath_sim > build.log 2>&1 \
    || { cat build.log; echo "build failed"; exit 1; }
./obj_dir/tb_datapath_sim > sim.log 2>&1
cat sim.log
grep -qx "PASS: all tests" sim.log \
    && echo "simulation passed" \
    || { echo "simulation failed"; exit 1; }

// File: rv32i_pkg.sv
// RV32I encodings and base types shared by the pipeline stages
// compile ahead of pipe_pkg and every RTL file
package rv32i_pkg;

    // data path width
    localparam int xlen = 32;
    // architectural register count
    localparam int nreg = 32;

    // one data or instruction word
    typedef logic [xlen-1:0] word_t;
    // register index
    typedef logic [$clog2(nreg)-1:0] reg_idx_t;

    // fetch starts here after reset
    localparam word_t reset_pc = '0;
    // sequential fetch only
    localparam word_t pc_step  = 32'd4;

    // major opcodes kept by this core
    // register-register alu
    localparam logic [6:0] op_reg   = 7'b0110011;
    // register-immediate alu
    localparam logic [6:0] op_imm   = 7'b0010011;
    localparam logic [6:0] op_lui   = 7'b0110111;
    localparam logic [6:0] op_load  = 7'b0000011;
    localparam logic [6:0] op_store = 7'b0100011;

    // funct3 for OP and OP-IMM
    localparam logic [2:0] f3_add   = 3'b000;
    localparam logic [2:0] f3_sll   = 3'b001;
    localparam logic [2:0] f3_slt   = 3'b010;
    localparam logic [2:0] f3_sltu  = 3'b011;
    localparam logic [2:0] f3_xor   = 3'b100;
    // srl or sra, told apart by funct7 bit 5
    localparam logic [2:0] f3_sr    = 3'b101;
    localparam logic [2:0] f3_or    = 3'b110;
    localparam logic [2:0] f3_and   = 3'b111;

    // word width for loads and stores
    // sub-word encodings decode as nop
    localparam logic [2:0] f3_lw_sw = 3'b010;

    // alu operations
    // add encodes as zero so an all-zero control word stays harmless
    typedef enum logic [3:0] {
        alu_add    = 4'd0,
        alu_sub    = 4'd1,
        alu_sll    = 4'd2,
        alu_slt    = 4'd3,
        alu_sltu   = 4'd4,
        alu_xor    = 4'd5,
        alu_srl    = 4'd6,
        alu_sra    = 4'd7,
        alu_or     = 4'd8,
        alu_and    = 4'd9,
        // operand b straight through, used by lui
        alu_pass_b = 4'd10
    } alu_op_e;

endpackage

// File: tb_datapath.sv
// testbench for the five-stage core: program table, memory models and store checker
// compares every SW against a table of expected stores
`timescale 1ns/100ps

module tb_datapath;

    localparam int imem_words = 64;
    localparam int dmem_words = 64;
    // cycles allowed between two stores
    localparam int store_timeout = 40;
    // addi x0, x0, 0
    localparam rv32i_pkg::word_t nop = 32'h0000_0013;
    localparam logic [6:0] opc_imm  = 7'b0010011;
    localparam logic [6:0] opc_load = 7'b0000011;

    // one expected store
    typedef struct packed {
        rv32i_pkg::word_t addr;
        rv32i_pkg::word_t data;
    } store_t;

    logic             clk = 1'b0;
    logic             arst_n_i;
    rv32i_pkg::word_t instr_mem_rdata, data_mem_rdata;
    rv32i_pkg::word_t instr_mem_address, data_mem_address, data_mem_wdata;
    logic             instr_mem_read, data_mem_read, data_mem_write;

    rv32i_pkg::word_t imem [imem_words];
    rv32i_pkg::word_t dmem [dmem_words];
    store_t           stores [$];
    // fetch addresses expected to repeat once, one per load-use pair
    rv32i_pkg::word_t hold_addr [$];
    // data addresses of the loads, in program order
    rv32i_pkg::word_t load_addr [$];
    int               n_instr = 0;
    int               hold_idx = 0;
    int               load_idx = 0;
    int               mismatches = 0;
    int               failures = 0;
    integer           seed;
    logic             fetch_seen = 1'b0;
    rv32i_pkg::word_t prev_fetch = '0;

    datapath datapath_inst (
        .clk(clk), .arst_n_i(arst_n_i),
        .instr_mem_rdata_i(instr_mem_rdata), .data_mem_rdata_i(data_mem_rdata),
        .instr_mem_address_o(instr_mem_address), .data_mem_address_o(data_mem_address),
        .data_mem_wdata_o(data_mem_wdata), .instr_mem_read_o(instr_mem_read),
        .data_mem_read_o(data_mem_read), .data_mem_write_o(data_mem_write)
    );

    initial begin
        forever #10 clk = ~clk;
    end

    // combinational memories, nop past the end of the program table
    assign instr_mem_rdata = (instr_mem_address < 32'(imem_words * 4)) ?
                             imem[instr_mem_address[7:2]] : nop;
    assign data_mem_rdata  = dmem[data_mem_address[7:2]];

    always @(posedge clk) begin
        if (data_mem_write) begin
            dmem[data_mem_address[7:2]] <= data_mem_wdata;
        end
    end

    // instruction encodings straight from the ISA formats
    function automatic rv32i_pkg::word_t r_format(input logic [6:0] f7, input logic [2:0] f3,
                                                  input logic [4:0] rd, rs1, rs2);
        return {f7, rs2, rs1, f3, rd, 7'b0110011};
    endfunction

    function automatic rv32i_pkg::word_t i_format(input logic [6:0] opc, input logic [2:0] f3,
                                                  input logic [4:0] rd, rs1,
                                                  input logic [11:0] imm);
        return {imm, rs1, f3, rd, opc};
    endfunction

    // sw rs2, imm(rs1)
    function automatic rv32i_pkg::word_t s_format(input logic [4:0] rs2, rs1,
                                                  input logic [11:0] imm);
        return {imm[11:5], rs2, rs1, 3'b010, imm[4:0], 7'b0100011};
    endfunction

    task automatic emit(input rv32i_pkg::word_t instr);
        imem[n_instr] = instr;
        n_instr++;
    endtask

    task automatic expect_store(input rv32i_pkg::word_t addr, input rv32i_pkg::word_t data);
        store_t s;
        s.addr = addr;
        s.data = data;
        stores.push_back(s);
    endtask

    task automatic build_program();
        // x6 .. x20 with x1 = -7 and x2 = 5
        rv32i_pkg::word_t alu_exp [15];
        alu_exp = '{32'h1, 32'h0, 32'hffff_fffc, 32'h07ff_ffff, 32'hffff_ffff, 32'hffff_fffd,
                    32'h1, 32'h1, 32'h1, 32'hffff_ff09, 32'h105, 32'h79, 32'd40,
                    32'h0fff_ffff, 32'hffff_fffc};
        emit(i_format(opc_imm, 3'b000, 5'd1, 5'd0, 12'hff9));
        emit(i_format(opc_imm, 3'b000, 5'd2, 5'd0, 12'd5));
        // x2 one back through EX/MEM, x1 two back through MEM/WB
        emit(r_format(7'h00, 3'b000, 5'd3, 5'd1, 5'd2));
        emit(s_format(5'd3, 5'd0, 12'h080));
        expect_store(32'h80, 32'hffff_fffe);
        emit(r_format(7'h20, 3'b000, 5'd4, 5'd2, 5'd1));
        emit(r_format(7'h00, 3'b001, 5'd5, 5'd2, 5'd2));
        // store data two back and then one more back
        emit(s_format(5'd4, 5'd0, 12'h084));
        emit(s_format(5'd5, 5'd0, 12'h088));
        expect_store(32'h84, 32'd12);
        expect_store(32'h88, 32'd160);
        // slt sltu xor srl sra or and
        emit(r_format(7'h00, 3'b010, 5'd6, 5'd1, 5'd2));
        emit(r_format(7'h00, 3'b011, 5'd7, 5'd1, 5'd2));
        emit(r_format(7'h00, 3'b100, 5'd8, 5'd1, 5'd2));
        emit(r_format(7'h00, 3'b101, 5'd9, 5'd1, 5'd2));
        emit(r_format(7'h20, 3'b101, 5'd10, 5'd1, 5'd2));
        emit(r_format(7'h00, 3'b110, 5'd11, 5'd1, 5'd2));
        emit(r_format(7'h00, 3'b111, 5'd12, 5'd1, 5'd2));
        // slti sltiu xori ori andi slli srli srai
        emit(i_format(opc_imm, 3'b010, 5'd13, 5'd1, 12'hffa));
        emit(i_format(opc_imm, 3'b011, 5'd14, 5'd2, 12'hfff));
        emit(i_format(opc_imm, 3'b100, 5'd15, 5'd1, 12'h0f0));
        emit(i_format(opc_imm, 3'b110, 5'd16, 5'd2, 12'h100));
        emit(i_format(opc_imm, 3'b111, 5'd17, 5'd1, 12'h07f));
        emit(i_format(opc_imm, 3'b001, 5'd18, 5'd2, 12'h003));
        emit(i_format(opc_imm, 3'b101, 5'd19, 5'd1, 12'h004));
        emit(i_format(opc_imm, 3'b101, 5'd20, 5'd1, 12'h401));
        for (int r = 6; r <= 20; r++) begin
            emit(s_format(5'(r), 5'd0, 12'(32'h80 + 4 * (r - 3))));
            expect_store(32'h80 + 4 * (r - 3), alu_exp[r - 6]);
        end
        // load-use on rs1, fetch sits one past the use while it waits
        emit(i_format(opc_load, 3'b010, 5'd21, 5'd0, 12'h010));
        load_addr.push_back(32'h10);
        emit(i_format(opc_imm, 3'b000, 5'd22, 5'd21, 12'd1));
        hold_addr.push_back(32'(4 * n_instr));
        emit(s_format(5'd22, 5'd0, 12'h0c0));
        expect_store(32'hc0, dmem[4] + 32'd1);
        // load-use on the store data
        emit(i_format(opc_load, 3'b010, 5'd23, 5'd0, 12'h014));
        load_addr.push_back(32'h14);
        emit(s_format(5'd23, 5'd0, 12'h0c4));
        hold_addr.push_back(32'(4 * n_instr));
        expect_store(32'hc4, dmem[5]);
        // lui, then a write to x0 that must not stick
        emit({20'habcde, 5'd24, 7'b0110111});
        emit(i_format(opc_imm, 3'b000, 5'd0, 5'd24, 12'h123));
        emit(s_format(5'd24, 5'd0, 12'h0c8));
        emit(s_format(5'd0, 5'd0, 12'h0cc));
        expect_store(32'hc8, 32'habcd_e000);
        expect_store(32'hcc, 32'h0);
    endtask

    // fetch address walks by four, repeats only at the load-use holds
    // read strobe low in the stall cycle, the first one at each hold address
    always @(negedge clk) begin
        logic at_hold;
        at_hold = hold_idx < hold_addr.size() && instr_mem_address == hold_addr[hold_idx];
        if (arst_n_i && !fetch_seen && instr_mem_read) begin
            fetch_seen = 1'b1;
            assert (instr_mem_address == 32'h0) else begin
                mismatches++;
                $display("Mismatch at %0t: first fetch at %h, expected 0", $time,
                         instr_mem_address);
            end
        end else if (fetch_seen && instr_mem_address == prev_fetch) begin
            assert (at_hold) else begin
                mismatches++;
                $display("Mismatch at %0t: fetch address %h held without a load-use pair",
                         $time, instr_mem_address);
            end
            assert (instr_mem_read) else begin
                mismatches++;
                $display("Mismatch at %0t: fetch read strobe low on the repeated fetch at %h",
                         $time, instr_mem_address);
            end
            hold_idx++;
        end else if (fetch_seen) begin
            assert (instr_mem_address == prev_fetch + 32'd4) else begin
                mismatches++;
                $display("Mismatch at %0t: fetch address %h, expected %h", $time,
                         instr_mem_address, prev_fetch + 32'd4);
            end
            assert (instr_mem_read == !at_hold) else begin
                mismatches++;
                $display("Mismatch at %0t: fetch read strobe %b at %h, expected %b", $time,
                         instr_mem_read, instr_mem_address, !at_hold);
            end
        end
        prev_fetch = instr_mem_address;
    end

    // each data read belongs to the next load of the program
    always @(negedge clk) begin
        if (data_mem_read) begin
            assert (load_idx < load_addr.size() && data_mem_address == load_addr[load_idx])
            else begin
                mismatches++;
                $display("Mismatch at %0t: data read at %h, expected load %0d", $time,
                         data_mem_address, load_idx);
            end
            load_idx++;
        end
    end

    initial begin
        int wait_cyc;
        bit timed_out;
        arst_n_i = 1'b0;
        seed = 19162;
        timed_out = 1'b0;
        for (int i = 0; i < dmem_words; i++) begin
            dmem[i] = $random(seed);
        end
        for (int i = 0; i < imem_words; i++) begin
            imem[i] = nop;
        end
        build_program();
        repeat (5) @(posedge clk);
        arst_n_i <= 1'b1;
        // one pass over the store table, each write sampled mid-cycle
        for (int k = 0; k < stores.size(); k++) begin
            wait_cyc = 0;
            @(negedge clk);
            while (!data_mem_write && wait_cyc < store_timeout) begin
                @(negedge clk);
                wait_cyc++;
            end
            if (!data_mem_write) begin
                failures++;
                $display("store %0d never reached data memory within %0d cycles",
                         k, store_timeout);
                timed_out = 1'b1;
                break;
            end
            assert (data_mem_address == stores[k].addr) else begin
                mismatches++;
                $display("Mismatch at %0t: store %0d address %h, expected %h", $time, k,
                         data_mem_address, stores[k].addr);
            end
            assert (data_mem_wdata == stores[k].data) else begin
                mismatches++;
                $display("Mismatch at %0t: store %0d data %h, expected %h", $time, k,
                         data_mem_wdata, stores[k].data);
            end
        end
        // trailing nops must stay off the data bus
        if (!timed_out) begin
            for (int c = 0; c < 12; c++) begin
                @(negedge clk);
                assert (!data_mem_write) else begin
                    failures++;
                    $display("unexpected store to %h after the last expected one",
                             data_mem_address);
                end
            end
            assert (hold_idx == hold_addr.size()) else begin
                failures++;
                $display("fetch held %0d times, %0d load-use holds expected",
                         hold_idx, hold_addr.size());
            end
            assert (load_idx == load_addr.size()) else begin
                failures++;
                $display("data memory read %0d times, %0d loads expected",
                         load_idx, load_addr.size());
            end
        end
        $display("errors: %0d mismatches, %0d other failures", mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("PASS: all tests");
        end else begin
            $display("FAIL: see errors above");
        end
        $finish;
    end

endmodule
